// ==== verilog/mbconv_pkg.sv ====
`default_nettype none

package mbconv_pkg;

    // channel geometry and arithmetic widths
    localparam int NUM_CH     = 4;
    localparam int DATA_W     = 8;
    localparam int ACC_W      = 20;
    localparam int POOL_ACC_W = 16;

    // ch0 sits in the low byte of the 32-bit word
    typedef struct packed {
        logic signed [DATA_W-1:0] ch3;
        logic signed [DATA_W-1:0] ch2;
        logic signed [DATA_W-1:0] ch1;
        logic signed [DATA_W-1:0] ch0;
    } pixel_t;

    // one weight per input channel
    typedef struct packed {
        logic signed [DATA_W-1:0] w3;
        logic signed [DATA_W-1:0] w2;
        logic signed [DATA_W-1:0] w1;
        logic signed [DATA_W-1:0] w0;
    } weight_row_t;

    typedef struct packed {
        logic [$clog2(NUM_CH)-1:0] oc;
        weight_row_t               row;
    } weight_wr_t;

    // row k holds the weights of output channel k
    typedef weight_row_t [NUM_CH-1:0] weight_mat_t;

    function automatic logic signed [DATA_W-1:0] pix_ch(input pixel_t p, input int idx);
        case (idx)
            0:       return p.ch0;
            1:       return p.ch1;
            2:       return p.ch2;
            default: return p.ch3;
        endcase
    endfunction

    function automatic pixel_t pix_set(input pixel_t p, input int idx,
                                       input logic [DATA_W-1:0] v);
        pixel_t r;
        r = p;
        case (idx)
            0:       r.ch0 = v;
            1:       r.ch1 = v;
            2:       r.ch2 = v;
            default: r.ch3 = v;
        endcase
        return r;
    endfunction

    function automatic logic signed [DATA_W-1:0] row_w(input weight_row_t r, input int idx);
        case (idx)
            0:       return r.w0;
            1:       return r.w1;
            2:       return r.w2;
            default: return r.w3;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/pw_weight_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_weight_bank (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  mbconv_pkg::weight_wr_t   wr,
    output mbconv_pkg::weight_mat_t  weights
);

    import mbconv_pkg::*;

    weight_mat_t bank_q;
    logic [NUM_CH-1:0] row_sel;

    // one-hot row select from the output-channel index
    always_comb begin
        for (int k = 0; k < NUM_CH; k++) begin
            row_sel[k] = wr_en && (wr.oc == k[$clog2(NUM_CH)-1:0]);
        end
    end

    genvar g;
    generate
        for (g = 0; g < NUM_CH; g++) begin : g_row
            // each row loads independently, so a load touches only its own channel
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    bank_q[g] <= '0;
                end else if (row_sel[g]) begin
                    bank_q[g] <= wr.row;
                end
            end
        end
    endgenerate

    // whole matrix always visible to the MAC stage
    assign weights = bank_q;

endmodule

`default_nettype wire

// ==== verilog/pw_mac_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module pw_mac_pipe #(
    parameter int unsigned REQ_SHIFT = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mbconv_pkg::weight_mat_t  weights,
    input  logic                     in_valid,
    input  mbconv_pkg::pixel_t       in_pix,
    output logic                     in_ready,
    output logic                     out_valid,
    output mbconv_pkg::pixel_t       out_pix,
    input  logic                     out_ready
);

    import mbconv_pkg::*;

    localparam int PROD_W    = 2 * DATA_W;
    localparam int CLAMP_MAX = (1 << (DATA_W - 1)) - 1;

    // stage 1 holds sixteen products
    logic                     s1_valid_q;
    logic signed [PROD_W-1:0] prod_q [NUM_CH][NUM_CH];

    // stage 2 holds the requantized output pixel
    logic                     s2_valid_q;
    pixel_t                   s2_pix_q;

    logic                     s2_ready;
    logic                     s1_load;

    logic signed [ACC_W-1:0]  acc     [NUM_CH];
    logic signed [ACC_W-1:0]  shifted [NUM_CH];
    logic [DATA_W-1:0]        relu    [NUM_CH];
    pixel_t                   s2_next;

    // stage 2 can take new data when empty or being drained
    assign s2_ready = !s2_valid_q || out_ready;
    assign in_ready = !s1_valid_q || s2_ready;
    assign s1_load  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else if (in_ready) begin
            s1_valid_q <= in_valid;
        end
    end

    // signed products of the accepted pixel with every weight
    always_ff @(posedge clk) begin
        if (s1_load) begin
            for (int k = 0; k < NUM_CH; k++) begin
                for (int i = 0; i < NUM_CH; i++) begin
                    prod_q[k][i] <= pix_ch(in_pix, i) * row_w(weights[k], i);
                end
            end
        end
    end

    // adder tree, arithmetic shift and relu clamp per output channel
    always_comb begin
        s2_next = '0;
        for (int k = 0; k < NUM_CH; k++) begin
            acc[k] = '0;
            for (int i = 0; i < NUM_CH; i++) begin
                acc[k] = acc[k] + prod_q[k][i];
            end
            shifted[k] = acc[k] >>> REQ_SHIFT;
            if (shifted[k] < 0) begin
                relu[k] = '0;
            end else if (shifted[k] > CLAMP_MAX) begin
                relu[k] = DATA_W'(CLAMP_MAX);
            end else begin
                relu[k] = shifted[k][DATA_W-1:0];
            end
            s2_next = pix_set(s2_next, k, relu[k]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid_q <= 1'b0;
        end else if (s2_ready) begin
            s2_valid_q <= s1_valid_q;
        end
    end

    // output data holds while the consumer stalls
    always_ff @(posedge clk) begin
        if (s2_ready && s1_valid_q) begin
            s2_pix_q <= s2_next;
        end
    end

    assign out_valid = s2_valid_q;
    assign out_pix   = s2_pix_q;

endmodule

`default_nettype wire

// ==== verilog/avg_pool_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module avg_pool_acc #(
    parameter int unsigned POOL_LEN = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  mbconv_pkg::pixel_t  in_pix,
    output logic                in_ready,
    output logic                out_valid,
    output mbconv_pkg::pixel_t  out_pix,
    input  logic                out_ready
);

    import mbconv_pkg::*;

    // window length is a power of two, so the average is a shift
    localparam int LOG2_LEN = $clog2(POOL_LEN);
    localparam int CNT_W    = (LOG2_LEN > 0) ? LOG2_LEN : 1;

    logic [CNT_W-1:0]             cnt_q;
    logic signed [POOL_ACC_W-1:0] sum_q   [NUM_CH];
    logic signed [POOL_ACC_W-1:0] sum_nx  [NUM_CH];
    logic signed [POOL_ACC_W-1:0] avg     [NUM_CH];
    logic                         out_valid_q;
    pixel_t                       out_pix_q;
    pixel_t                       avg_pix;
    logic                         accept;
    logic                         last;

    // no new pixels while a pooled result waits
    assign in_ready = !out_valid_q;
    assign accept   = in_valid && in_ready;
    assign last     = (cnt_q == CNT_W'(POOL_LEN - 1));

    always_comb begin
        avg_pix = '0;
        for (int k = 0; k < NUM_CH; k++) begin
            sum_nx[k] = sum_q[k] + pix_ch(in_pix, k);
            avg[k]    = sum_nx[k] >>> LOG2_LEN;
            avg_pix   = pix_set(avg_pix, k, avg[k][DATA_W-1:0]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q       <= '0;
            out_valid_q <= 1'b0;
            for (int k = 0; k < NUM_CH; k++) begin
                sum_q[k] <= '0;
            end
        end else begin
            if (accept) begin
                if (last) begin
                    // last pixel of the window restarts count and sums
                    cnt_q       <= '0;
                    out_valid_q <= 1'b1;
                    for (int k = 0; k < NUM_CH; k++) begin
                        sum_q[k] <= '0;
                    end
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                    for (int k = 0; k < NUM_CH; k++) begin
                        sum_q[k] <= sum_nx[k];
                    end
                end
            end else if (out_valid_q && out_ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && last) begin
            out_pix_q <= avg_pix;
        end
    end

    assign out_valid = out_valid_q;
    assign out_pix   = out_pix_q;

endmodule

`default_nettype wire

// ==== verilog/mbconv_lite_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbconv_lite_top #(
    parameter int unsigned REQ_SHIFT = 4,
    parameter int unsigned POOL_LEN  = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // weight load port
    input  logic                    wt_wr_en,
    input  mbconv_pkg::weight_wr_t  wt_wr,

    // pixel stream in
    input  logic                    pix_in_valid,
    input  mbconv_pkg::pixel_t      pix_in,
    output logic                    pix_in_ready,

    // pointwise feature map out
    output logic                    fmap_valid,
    output mbconv_pkg::pixel_t      fmap,
    input  logic                    fmap_ready,

    // pooled pixel out
    output logic                    pool_valid,
    output mbconv_pkg::pixel_t      pool,
    input  logic                    pool_ready
);

    import mbconv_pkg::*;

    weight_mat_t weights;
    logic        pipe_out_valid;
    logic        pipe_out_ready;
    logic        pool_in_valid;
    logic        pool_in_ready;

    pw_weight_bank u_weight_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wt_wr_en),
        .wr      (wt_wr),
        .weights (weights)
    );

    pw_mac_pipe #(
        .REQ_SHIFT (REQ_SHIFT)
    ) u_mac_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .weights   (weights),
        .in_valid  (pix_in_valid),
        .in_pix    (pix_in),
        .in_ready  (pix_in_ready),
        .out_valid (pipe_out_valid),
        .out_pix   (fmap),
        .out_ready (pipe_out_ready)
    );

    // a pixel leaves only when both fmap and the pooling side take it
    assign pipe_out_ready = fmap_ready && pool_in_ready;
    assign fmap_valid     = pipe_out_valid && pool_in_ready;
    assign pool_in_valid  = pipe_out_valid && fmap_ready;

    avg_pool_acc #(
        .POOL_LEN (POOL_LEN)
    ) u_pool (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pool_in_valid),
        .in_pix    (fmap),
        .in_ready  (pool_in_ready),
        .out_valid (pool_valid),
        .out_pix   (pool),
        .out_ready (pool_ready)
    );

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== verification/mbconv_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbconv_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               fmap_valid,
    input logic               fmap_ready,
    input mbconv_pkg::pixel_t fmap,
    input logic               pool_valid,
    input logic               pool_ready,
    input mbconv_pkg::pixel_t pool
);

    import mbconv_pkg::*;

    // relu output is never negative and never above 127
    function automatic logic in_range(input pixel_t p);
        return (p.ch0 >= 0) && (p.ch1 >= 0) && (p.ch2 >= 0) && (p.ch3 >= 0);
    endfunction

    a_fmap_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fmap_valid && !fmap_ready |=> fmap_valid && $stable(fmap))
        else $error("fmap dropped or changed while stalled");

    a_pool_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pool_valid && !pool_ready |=> pool_valid && $stable(pool))
        else $error("pool dropped or changed while stalled");

    a_range: assert property (@(posedge clk) disable iff (!rst_n)
        (!fmap_valid || in_range(fmap)) && (!pool_valid || in_range(pool)))
        else $error("channel value outside 0..127");

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    import mbconv_pkg::*;

    localparam int REQ_SHIFT      = 4;
    localparam int POOL_LEN       = 16;
    // well above the combined length of all five tests
    localparam int TIMEOUT_CYCLES = 3000;

    logic       clk;
    logic       rst_n;
    logic       wt_wr_en;
    weight_wr_t wt_wr;
    logic       pix_in_valid;
    pixel_t     pix_in;
    logic       pix_in_ready;
    logic       fmap_valid;
    pixel_t     fmap;
    logic       fmap_ready;
    logic       pool_valid;
    pixel_t     pool;
    logic       pool_ready;

    int     w_model [NUM_CH][NUM_CH];
    int     win_sum [NUM_CH];
    int     win_cnt;
    pixel_t exp_fmap_q [$];
    pixel_t exp_pool_q [$];
    int     err_cnt;
    int     pass_cnt;
    int     fail_cnt;
    int     cycle_cnt;
    bit     send_done;

    clk_gen #(.PERIOD(20), .RST_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    mbconv_lite_top #(
        .REQ_SHIFT (REQ_SHIFT),
        .POOL_LEN  (POOL_LEN)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wt_wr_en     (wt_wr_en),
        .wt_wr        (wt_wr),
        .pix_in_valid (pix_in_valid),
        .pix_in       (pix_in),
        .pix_in_ready (pix_in_ready),
        .fmap_valid   (fmap_valid),
        .fmap         (fmap),
        .fmap_ready   (fmap_ready),
        .pool_valid   (pool_valid),
        .pool         (pool),
        .pool_ready   (pool_ready)
    );

    bind mbconv_lite_top mbconv_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .fmap_valid (fmap_valid),
        .fmap_ready (fmap_ready),
        .fmap       (fmap),
        .pool_valid (pool_valid),
        .pool_ready (pool_ready),
        .pool       (pool)
    );

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // sum of products, arithmetic shift, then clamp to 0..127
    function automatic pixel_t pw_model(input pixel_t x);
        int     xs [NUM_CH];
        int     q  [NUM_CH];
        int     acc;
        pixel_t r;
        xs[0] = x.ch0;
        xs[1] = x.ch1;
        xs[2] = x.ch2;
        xs[3] = x.ch3;
        for (int k = 0; k < NUM_CH; k++) begin
            acc = 0;
            for (int i = 0; i < NUM_CH; i++) begin
                acc += w_model[k][i] * xs[i];
            end
            acc = acc >>> REQ_SHIFT;
            if (acc < 0) begin
                acc = 0;
            end else if (acc > 127) begin
                acc = 127;
            end
            q[k] = acc;
        end
        r.ch0 = 8'(q[0]);
        r.ch1 = 8'(q[1]);
        r.ch2 = 8'(q[2]);
        r.ch3 = 8'(q[3]);
        return r;
    endfunction

    // queue the feature pixel and fold it into the current window
    task automatic push_expected(input pixel_t p);
        pixel_t e;
        pixel_t avg;
        e = pw_model(p);
        exp_fmap_q.push_back(e);
        win_sum[0] += e.ch0;
        win_sum[1] += e.ch1;
        win_sum[2] += e.ch2;
        win_sum[3] += e.ch3;
        win_cnt++;
        if (win_cnt == POOL_LEN) begin
            avg.ch0 = 8'(win_sum[0] / POOL_LEN);
            avg.ch1 = 8'(win_sum[1] / POOL_LEN);
            avg.ch2 = 8'(win_sum[2] / POOL_LEN);
            avg.ch3 = 8'(win_sum[3] / POOL_LEN);
            exp_pool_q.push_back(avg);
            win_sum = '{default: 0};
            win_cnt = 0;
        end
    endtask

    function automatic pixel_t rand_pixel();
        pixel_t p;
        p.ch0 = 8'($urandom);
        p.ch1 = 8'($urandom);
        p.ch2 = 8'($urandom);
        p.ch3 = 8'($urandom);
        return p;
    endfunction

    task automatic load_weights();
        weight_wr_t wr;
        for (int k = 0; k < NUM_CH; k++) begin
            wr.oc     = 2'(k);
            wr.row.w0 = 8'(w_model[k][0]);
            wr.row.w1 = 8'(w_model[k][1]);
            wr.row.w2 = 8'(w_model[k][2]);
            wr.row.w3 = 8'(w_model[k][3]);
            @(posedge clk);
            wt_wr_en <= 1'b1;
            wt_wr    <= wr;
        end
        @(posedge clk);
        wt_wr_en <= 1'b0;
    endtask

    // transfer happens on the edge after the negedge where ready is seen
    task automatic send_pixel(input pixel_t p, input bit ready_check);
        @(posedge clk);
        pix_in_valid <= 1'b1;
        pix_in       <= p;
        @(negedge clk);
        while (!pix_in_ready) begin
            // only a pending pooled result may hold the input off
            if (ready_check && !pool_valid) begin
                check_bit("pix_in_ready", 1'b1, pix_in_ready);
            end
            @(negedge clk);
        end
        push_expected(p);
    endtask

    task automatic release_input();
        @(posedge clk);
        pix_in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (exp_fmap_q.size() != 0 || exp_pool_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: passed", name);
            pass_cnt++;
        end else begin
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    task automatic test_reset_state();
        int errs0;
        errs0 = err_cnt;
        @(negedge clk);
        check_bit("pix_in_ready", 1'b1, pix_in_ready);
        check_bit("fmap_valid", 1'b0, fmap_valid);
        check_bit("pool_valid", 1'b0, pool_valid);
        // zero weights give a zero feature pixel
        send_pixel(32'h11_f3_40_85, 1'b0);
        release_input();
        wait_drain();
        finish_test("reset state", errs0);
    endtask

    task automatic test_single_pixel();
        int errs0;
        errs0 = err_cnt;
        // row 0 mid value, row 1 clamps to zero, row 2 saturates, row 3 small
        w_model[0] = '{20, -10, 20, 10};
        w_model[1] = '{0, 3, -5, 10};
        w_model[2] = '{100, -127, 127, 127};
        w_model[3] = '{1, 0, 1, 1};
        load_weights();
        send_pixel(32'h05_1e_ec_0a, 1'b0);
        release_input();
        wait_drain();
        finish_test("single pixel", errs0);
    endtask

    task automatic test_stream();
        int errs0;
        errs0 = err_cnt;
        for (int k = 0; k < NUM_CH; k++) begin
            for (int i = 0; i < NUM_CH; i++) begin
                w_model[k][i] = int'($urandom_range(0, 15)) - 8;
            end
        end
        load_weights();
        for (int n = 0; n < 32; n++) begin
            send_pixel(rand_pixel(), 1'b1);
        end
        release_input();
        wait_drain();
        finish_test("back-to-back stream", errs0);
    endtask

    task automatic test_backpressure();
        int errs0;
        errs0 = err_cnt;
        send_done = 1'b0;
        fork
            begin
                for (int n = 0; n < 32; n++) begin
                    send_pixel(rand_pixel(), 1'b0);
                end
                send_done = 1'b1;
                release_input();
            end
            begin
                while (!send_done) begin
                    @(posedge clk);
                    if (send_done) begin
                        fmap_ready <= 1'b1;
                    end else begin
                        fmap_ready <= 1'($urandom_range(0, 1));
                    end
                end
            end
        join
        wait_drain();
        finish_test("back-pressure", errs0);
    endtask

    task automatic test_pooling();
        int errs0;
        errs0 = err_cnt;
        @(posedge clk);
        pool_ready <= 1'b0;
        fork
            begin
                for (int n = 0; n < 2 * POOL_LEN; n++) begin
                    send_pixel(rand_pixel(), 1'b0);
                end
                release_input();
            end
            begin
                @(negedge clk);
                while (!pool_valid) begin
                    @(negedge clk);
                end
                // result held and fmap stalled until the pool is taken
                repeat (4) begin
                    check_bit("pool_valid", 1'b1, pool_valid);
                    check_bit("fmap_valid", 1'b0, fmap_valid);
                    @(negedge clk);
                end
                @(posedge clk);
                pool_ready <= 1'b1;
            end
        join
        wait_drain();
        finish_test("pooling", errs0);
    endtask

    // compare every transfer while its data is stable
    always @(negedge clk) begin
        if (rst_n) begin
            if (fmap_valid && fmap_ready) begin
                if (exp_fmap_q.size() == 0) begin
                    $display("Error at %0t ns: fmap transfer with no pixel outstanding", $time);
                    err_cnt++;
                end else begin
                    check_pixel("fmap", exp_fmap_q.pop_front(), fmap);
                end
            end
            if (pool_valid && pool_ready) begin
                if (exp_pool_q.size() == 0) begin
                    $display("Error at %0t ns: pool transfer with no window complete", $time);
                    err_cnt++;
                end else begin
                    check_pixel("pool", exp_pool_q.pop_front(), pool);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(63));
        wt_wr_en     = 1'b0;
        wt_wr        = '0;
        pix_in_valid = 1'b0;
        pix_in       = '0;
        fmap_ready   = 1'b1;
        pool_ready   = 1'b1;
        w_model      = '{default: '{default: 0}};
        win_sum      = '{default: 0};
        win_cnt      = 0;
        err_cnt      = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        cycle_cnt    = 0;
        send_done    = 1'b0;
        wait (rst_n === 1'b1);
        test_reset_state();
        test_single_pixel();
        test_stream();
        test_backpressure();
        test_pooling();
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/mbconv_pkg.sv
verilog/pw_weight_bank.sv
verilog/pw_mac_pipe.sv
verilog/avg_pool_acc.sv
verilog/mbconv_lite_top.sv
verification/clk_gen.sv
verification/mbconv_checker.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
